/* verilog/axil_pkg.sv */
package axil_pkg;

    // ******************************************************************
    // Bus widths
    // ******************************************************************

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [addr_w-1:0] axil_addr_t;
    typedef logic [data_w-1:0] axil_data_t;
    typedef logic [strb_w-1:0] axil_strb_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    // ******************************************************************
    // Channel bundles
    // ******************************************************************

    // Manager to subordinate.
    typedef struct packed {
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
    } axil_req_t;

    // Subordinate to manager.
    typedef struct packed {
        logic       arready;
        axil_data_t rdata;
        axil_resp_e rresp;
        logic       rvalid;
        logic       awready;
        logic       wready;
        axil_resp_e bresp;
        logic       bvalid;
    } axil_rsp_t;

endpackage

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;

    import axil_pkg::*;

    // ******************************************************************
    // Address map
    // ******************************************************************

    localparam int num_windows = 3;

    localparam int win_mem    = 0;  // Main memory.
    localparam int win_serial = 1;  // Serial port window.
    localparam int win_timer  = 2;  // Timer window.

    // Every base sits on a 64 byte boundary.
    localparam axil_addr_t window_base [num_windows] = '{
        win_mem:    32'h8000_0000,
        win_serial: 32'ha000_03c0,
        win_timer:  32'ha000_0040
    };

    typedef enum logic [2:0] {
        SEL_IDLE,
        SEL_WIN0,
        SEL_WIN1,
        SEL_WIN2,
        SEL_ERR
    } xbar_sel_e;

    // Selection code that belongs to window idx.
    function automatic xbar_sel_e win_sel(input int idx);
        return xbar_sel_e'(SEL_WIN0 + idx);
    endfunction

endpackage

/* verilog/xbar_route.sv */
`timescale 1ns/1ps

module xbar_route
    import axil_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int RAM_WORDS = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t m_req,
    input  logic      done,
    output axil_req_t bank_req [num_windows],
    output xbar_sel_e sel
);

    localparam axil_addr_t win_bytes = axil_addr_t'(RAM_WORDS * 4);

    axil_addr_t dec_addr;
    logic       dec_valid;
    xbar_sel_e  dec_sel;
    logic       rd_txn;
    axil_req_t  fwd_req;

    // ******************************************************************
    // Address decode
    // ******************************************************************

    assign dec_addr  = m_req.arvalid ? m_req.araddr : m_req.awaddr;  // Read wins.
    assign dec_valid = m_req.arvalid | m_req.awvalid;

    always_comb begin
        dec_sel = SEL_ERR;  // No window hit.
        for (int i = 0; i < num_windows; i++) begin
            if (dec_addr >= window_base[i] && dec_addr < window_base[i] + win_bytes) begin
                dec_sel = win_sel(i);
            end
        end
    end

    // ******************************************************************
    // Selection register
    // ******************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel    <= SEL_IDLE;
            rd_txn <= 1'b0;
        end else if (sel == SEL_IDLE) begin
            if (dec_valid) begin
                sel    <= dec_sel;
                rd_txn <= m_req.arvalid;  // Remember which channel owns the slot.
            end
        end else if (done) begin
            sel <= SEL_IDLE;
        end
    end

    // ******************************************************************
    // Request fan-out
    // ******************************************************************

    // Only the channel that won the decode reaches the bank.
    always_comb begin
        fwd_req = m_req;
        if (rd_txn) begin
            fwd_req.awvalid = 1'b0;
            fwd_req.wvalid  = 1'b0;
            fwd_req.bready  = 1'b0;
        end else begin
            fwd_req.arvalid = 1'b0;
            fwd_req.rready  = 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < num_windows; i++) begin
            bank_req[i] = (sel == win_sel(i)) ? fwd_req : '0;  // Idle banks see zeros.
        end
    end

endmodule

/* verilog/xbar_merge.sv */
`timescale 1ns/1ps

module xbar_merge
    import axil_pkg::*;
    import soc_map_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  xbar_sel_e sel,
    input  axil_req_t m_req,
    input  axil_rsp_t bank_rsp [num_windows],
    output axil_rsp_t m_rsp,
    output logic      done
);

    typedef enum logic {
        ERR_ACCEPT,
        ERR_RESP
    } err_state_e;

    err_state_e err_state;
    logic       err_rd;
    logic       err_ar_hs;
    logic       err_aw_hs;
    axil_rsp_t  err_rsp;
    axil_rsp_t  win_rsp;

    // ******************************************************************
    // Window response mux
    // ******************************************************************

    always_comb begin
        win_rsp = '0;  // Also covers SEL_IDLE.
        for (int i = 0; i < num_windows; i++) begin
            if (sel == win_sel(i)) begin
                win_rsp = bank_rsp[i];
            end
        end
    end

    // ******************************************************************
    // Decode error responder
    // ******************************************************************

    assign err_ar_hs = (sel == SEL_ERR) && (err_state == ERR_ACCEPT) && m_req.arvalid;
    assign err_aw_hs = (sel == SEL_ERR) && (err_state == ERR_ACCEPT) && !m_req.arvalid
                       && m_req.awvalid && m_req.wvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_state <= ERR_ACCEPT;
            err_rd    <= 1'b0;
        end else begin
            case (err_state)
                ERR_ACCEPT: begin
                    if (err_ar_hs || err_aw_hs) begin
                        err_state <= ERR_RESP;
                        err_rd    <= err_ar_hs;
                    end
                end
                ERR_RESP: begin
                    if (done) begin
                        err_state <= ERR_ACCEPT;  // Manager took the error.
                    end
                end
                default: err_state <= ERR_ACCEPT;
            endcase
        end
    end

    always_comb begin
        err_rsp         = '0;
        err_rsp.arready = err_ar_hs;
        err_rsp.awready = err_aw_hs;
        err_rsp.wready  = err_aw_hs;  // Address and data go together.
        if (err_state == ERR_RESP) begin
            if (err_rd) begin
                err_rsp.rvalid = 1'b1;
                err_rsp.rresp  = RESP_DECERR;  // rdata stays zero.
            end else begin
                err_rsp.bvalid = 1'b1;
                err_rsp.bresp  = RESP_DECERR;
            end
        end
    end

    // ******************************************************************
    // Manager side
    // ******************************************************************

    assign m_rsp = (sel == SEL_ERR) ? err_rsp : win_rsp;

    // Final response accepted by the manager.
    assign done = (m_rsp.rvalid & m_req.rready) | (m_rsp.bvalid & m_req.bready);

endmodule

/* verilog/axil_ram.sv */
`timescale 1ns/1ps

module axil_ram
    import axil_pkg::*;
#(
    parameter int RAM_WORDS = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t req,
    output axil_rsp_t rsp
);

    localparam int idx_w = $clog2(RAM_WORDS);

    axil_data_t mem [RAM_WORDS];

    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic             ar_rdy;
    logic             r_vld;
    logic             w_rdy;
    logic             b_vld;
    logic             ar_hs;
    logic             wr_hs;
    axil_data_t       r_data;

    assign rd_idx = req.araddr[idx_w+1:2];  // Word index, wraps inside the bank.
    assign wr_idx = req.awaddr[idx_w+1:2];

    assign ar_hs = req.arvalid & ar_rdy;
    assign wr_hs = req.awvalid & req.wvalid & w_rdy;

    // ******************************************************************
    // Read channel
    // ******************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ar_rdy <= 1'b0;
            r_vld  <= 1'b0;
        end else begin
            ar_rdy <= req.arvalid & ~ar_rdy & ~r_vld;  // One cycle pulse.
            if (ar_hs) begin
                r_vld <= 1'b1;
            end else if (r_vld & req.rready) begin
                r_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r_data <= mem[rd_idx];  // Held until the next accepted read.
        end
    end

    // ******************************************************************
    // Write channel
    // ******************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_rdy <= 1'b0;
            b_vld <= 1'b0;
        end else begin
            w_rdy <= req.awvalid & req.wvalid & ~w_rdy & ~b_vld;
            if (wr_hs) begin
                b_vld <= 1'b1;
            end else if (b_vld & req.bready) begin
                b_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int b = 0; b < strb_w; b++) begin
                if (req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // ******************************************************************
    // Response bundle
    // ******************************************************************

    always_comb begin
        rsp         = '0;
        rsp.arready = ar_rdy;
        rsp.rdata   = r_data;
        rsp.rresp   = RESP_OKAY;
        rsp.rvalid  = r_vld;
        rsp.awready = w_rdy;
        rsp.wready  = w_rdy;
        rsp.bresp   = RESP_OKAY;
        rsp.bvalid  = b_vld;
    end

endmodule

/* verilog/axil_subsys_top.sv */
`timescale 1ns/1ps

module axil_subsys_top
    import axil_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int RAM_WORDS = 16,
    parameter int NUM_BANKS = num_windows
) (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t m_req,
    output axil_rsp_t m_rsp
);

    axil_req_t bank_req [NUM_BANKS];
    axil_rsp_t bank_rsp [NUM_BANKS];
    xbar_sel_e sel;
    logic      done;

    // ******************************************************************
    // Crossbar request side
    // ******************************************************************

    xbar_route #(
        .RAM_WORDS (RAM_WORDS)
    ) i_route (
        .clk      (clk),
        .rst      (rst),
        .m_req    (m_req),
        .done     (done),
        .bank_req (bank_req),
        .sel      (sel)
    );

    // ******************************************************************
    // Memory banks
    // ******************************************************************

    // One bank per window, serial and timer included.
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        axil_ram #(
            .RAM_WORDS (RAM_WORDS)
        ) i_ram (
            .clk (clk),
            .rst (rst),
            .req (bank_req[i]),
            .rsp (bank_rsp[i])
        );
    end

    // ******************************************************************
    // Crossbar response side
    // ******************************************************************

    xbar_merge i_merge (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .m_req    (m_req),
        .bank_rsp (bank_rsp),
        .m_rsp    (m_rsp),
        .done     (done)
    );

endmodule

/* tb/tb_axil_subsys.sv */
`timescale 1ns/1ps

module tb_axil_subsys
    import axil_pkg::*;
();

    localparam int ram_words      = 16;
    localparam int num_rows       = 21;
    localparam int timeout_cycles = 50;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_e;

    typedef enum int {
        WAIT_AR,
        WAIT_R,
        WAIT_W,
        WAIT_B
    } wait_e;

    logic      clk;
    logic      rst;
    axil_req_t m_req;
    axil_rsp_t m_rsp;

    string      row_name  [num_rows];
    op_e        row_op    [num_rows];
    axil_addr_t row_addr  [num_rows];
    axil_data_t row_wdata [num_rows];
    axil_strb_t row_wstrb [num_rows];
    axil_data_t row_rdata [num_rows];
    axil_resp_e row_resp  [num_rows];
    int         row_stall [num_rows];

    int     row_cnt;
    int     pass_cnt;
    int     fail_cnt;
    int     err_cnt;  // Errors in the running test.
    integer seed;

    axil_subsys_top #(
        .RAM_WORDS (ram_words)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .m_req (m_req),
        .m_rsp (m_rsp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ******************************************************************
    // Stimulus table
    // ******************************************************************

    // Reads get 0 to 3 extra rready low cycles on top of min_stall.
    task automatic add_row(input string name, input op_e op, input axil_addr_t addr,
                           input axil_data_t wdata, input axil_strb_t wstrb,
                           input axil_data_t rdata, input axil_resp_e resp,
                           input int min_stall);
        row_name[row_cnt]  = name;
        row_op[row_cnt]    = op;
        row_addr[row_cnt]  = addr;
        row_wdata[row_cnt] = wdata;
        row_wstrb[row_cnt] = wstrb;
        row_rdata[row_cnt] = rdata;
        row_resp[row_cnt]  = resp;
        row_stall[row_cnt] = (op == OP_READ) ? min_stall + $unsigned($random(seed)) % 4 : 0;
        row_cnt++;
    endtask

    task automatic build_table();
        add_row("w0_word_wr", OP_WRITE, 32'h8000_0004, 32'h1122_3344, 4'hf, '0, RESP_OKAY, 0);
        add_row("w0_word_rd", OP_READ, 32'h8000_0004, '0, '0, 32'h1122_3344, RESP_OKAY, 0);
        add_row("w1_word_wr", OP_WRITE, 32'ha000_03c8, 32'h5566_7788, 4'hf, '0, RESP_OKAY, 0);
        add_row("w1_word_rd", OP_READ, 32'ha000_03c8, '0, '0, 32'h5566_7788, RESP_OKAY, 0);
        add_row("w2_word_wr", OP_WRITE, 32'ha000_0078, 32'h99aa_bbcc, 4'hf, '0, RESP_OKAY, 0);
        add_row("w2_word_rd", OP_READ, 32'ha000_0078, '0, '0, 32'h99aa_bbcc, RESP_OKAY, 0);
        // Bytes 0 and 2 come from the second write.
        add_row("strb_base_wr", OP_WRITE, 32'h8000_0010, 32'ha1b2_c3d4, 4'hf, '0, RESP_OKAY, 0);
        add_row("strb_0101_wr", OP_WRITE, 32'h8000_0010, 32'h1122_3344, 4'h5, '0, RESP_OKAY, 0);
        add_row("strb_0101_rd", OP_READ, 32'h8000_0010, '0, '0, 32'ha122_c344, RESP_OKAY, 0);
        // Offset 0x20 in every window lands on word 8 of its own bank.
        add_row("iso_w0_wr", OP_WRITE, 32'h8000_0020, 32'h0000_0a0a, 4'hf, '0, RESP_OKAY, 0);
        add_row("iso_w1_wr", OP_WRITE, 32'ha000_03e0, 32'h0000_0b0b, 4'hf, '0, RESP_OKAY, 0);
        add_row("iso_w2_wr", OP_WRITE, 32'ha000_0060, 32'h0000_0c0c, 4'hf, '0, RESP_OKAY, 0);
        add_row("iso_w0_rd", OP_READ, 32'h8000_0020, '0, '0, 32'h0000_0a0a, RESP_OKAY, 0);
        add_row("iso_w1_rd", OP_READ, 32'ha000_03e0, '0, '0, 32'h0000_0b0b, RESP_OKAY, 0);
        add_row("iso_w2_rd", OP_READ, 32'ha000_0060, '0, '0, 32'h0000_0c0c, RESP_OKAY, 0);
        add_row("decerr_rd", OP_READ, 32'h9000_0000, '0, '0, '0, RESP_DECERR, 0);
        add_row("decerr_wr", OP_WRITE, 32'h9000_0000, 32'hdead_beef, 4'hf, '0, RESP_DECERR, 0);
        // Just past window 1.
        add_row("decerr_gap_rd", OP_READ, 32'ha000_0400, '0, '0, '0, RESP_DECERR, 0);
        add_row("post_err_rd", OP_READ, 32'h8000_0004, '0, '0, 32'h1122_3344, RESP_OKAY, 0);
        add_row("bp_w1_rd", OP_READ, 32'ha000_03c8, '0, '0, 32'h5566_7788, RESP_OKAY, 3);
        add_row("bp_w2_rd", OP_READ, 32'ha000_0078, '0, '0, 32'h99aa_bbcc, RESP_OKAY, 3);
    endtask

    // ******************************************************************
    // Compare tasks
    // ******************************************************************

    task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
        if (act !== exp) begin
            $display("Mismatch %s rdata: expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
        if (act !== exp) begin
            $display("Mismatch %s resp: expected %s actual %s (%b)", name, exp.name(), act.name(),
                     act);
            err_cnt++;
        end
    endtask

    task automatic check_idle(input string name, input axil_rsp_t rsp);
        logic [4:0] flags;
        flags = {rsp.arready, rsp.rvalid, rsp.awready, rsp.wready, rsp.bvalid};
        if (flags !== 5'b0) begin
            $display("Mismatch %s handshake flags: expected %b actual %b", name, 5'b0, flags);
            err_cnt++;
        end
    endtask

    // ******************************************************************
    // Bus tasks
    // ******************************************************************

    function automatic logic flag_high(input wait_e what);
        case (what)
            WAIT_AR: return m_rsp.arready;
            WAIT_R:  return m_rsp.rvalid;
            WAIT_W:  return m_rsp.awready & m_rsp.wready;
            default: return m_rsp.bvalid;
        endcase
    endfunction

    // Returns at the rising edge where the flag is seen high.
    task automatic wait_for(input string name, input wait_e what, input string what_txt,
                            output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < timeout_cycles) begin
            @(posedge clk);
            ok = flag_high(what);
            cycles++;
        end
        if (!ok) begin
            $display("Timeout in %s: %s never came from the subsystem", name, what_txt);
            err_cnt++;
        end
    endtask

    task automatic write_txn(input int idx);
        bit         ok;
        axil_resp_e resp;
        @(negedge clk);
        m_req.awaddr  = row_addr[idx];
        m_req.awvalid = 1'b1;
        m_req.wdata   = row_wdata[idx];
        m_req.wstrb   = row_wstrb[idx];
        m_req.wvalid  = 1'b1;
        wait_for(row_name[idx], WAIT_W, "awready and wready", ok);
        @(negedge clk);
        m_req.awvalid = 1'b0;
        m_req.wvalid  = 1'b0;
        if (ok) begin
            wait_for(row_name[idx], WAIT_B, "bvalid", ok);
        end
        if (ok) begin
            @(negedge clk);
            m_req.bready = 1'b1;
            @(posedge clk);
            resp = m_rsp.bresp;
            @(negedge clk);
            m_req.bready = 1'b0;
            check_resp(row_name[idx], row_resp[idx], resp);
        end
    endtask

    task automatic read_txn(input int idx);
        bit         ok;
        int         stall;
        axil_data_t held;
        axil_data_t data;
        axil_resp_e resp;
        @(negedge clk);
        m_req.araddr  = row_addr[idx];
        m_req.arvalid = 1'b1;
        wait_for(row_name[idx], WAIT_AR, "arready", ok);
        @(negedge clk);
        m_req.arvalid = 1'b0;
        if (ok) begin
            wait_for(row_name[idx], WAIT_R, "rvalid", ok);
        end
        if (ok) begin
            held = m_rsp.rdata;
            for (stall = 0; stall < row_stall[idx]; stall++) begin
                @(posedge clk);
                if (m_rsp.rvalid !== 1'b1 || m_rsp.rdata !== held) begin
                    $display("Read response in %s changed while rready was low", row_name[idx]);
                    err_cnt++;
                end
            end
            @(negedge clk);
            m_req.rready = 1'b1;
            @(posedge clk);
            data = m_rsp.rdata;
            resp = m_rsp.rresp;
            @(negedge clk);
            m_req.rready = 1'b0;
            check_data(row_name[idx], row_rdata[idx], data);
            check_resp(row_name[idx], row_resp[idx], resp);
        end
    endtask

    task automatic report_test(input string name);
        if (err_cnt == 0) begin
            pass_cnt++;
            $display("PASS %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", name, err_cnt);
        end
        err_cnt = 0;
    endtask

    // ******************************************************************
    // Main sequence
    // ******************************************************************

    initial begin
        seed     = 32'hafb7_48de;
        rst      = 1'b1;
        m_req    = '0;
        row_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        err_cnt  = 0;
        build_table();

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(posedge clk);
        check_idle("reset_idle", m_rsp);  // Nothing driven yet.
        report_test("reset_idle");

        for (int i = 0; i < row_cnt; i++) begin
            if (row_op[i] == OP_WRITE) begin
                write_txn(i);
            end else begin
                read_txn(i);
            end
            report_test(row_name[i]);
        end

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/axil_pkg.sv
verilog/soc_map_pkg.sv
verilog/xbar_route.sv
verilog/xbar_merge.sv
verilog/axil_ram.sv
verilog/axil_subsys_top.sv
tb/tb_axil_subsys.sv
